/* hw/TryPadPkg.sv */
//--------------------------------------------------------------------
// Shared types and constants for the game-pad push-switch path.
// Holds the APB request/response structs, the per-switch event
// struct, the register map of the switch CSR block and its reset
// values. Imported by wildcard in the module headers that need it.
//--------------------------------------------------------------------
package TryPadPkg;

	//----------------------------------------------------------------------
	// APB bus
	//----------------------------------------------------------------------
	// Master to slave, 42 bits
	typedef struct packed {
		logic			psel;
		logic			penable;
		logic			pwrite;
		logic [6:0]		paddr;		// Byte address
		logic [31:0]	pwdata;
	} apbReq_t;

	// Slave to master, 34 bits
	typedef struct packed {
		logic [31:0]	prdata;
		logic			pready;
		logic			pslverr;
	} apbRsp_t;

	//----------------------------------------------------------------------
	// Switch channel
	//----------------------------------------------------------------------
	// One debounced switch as seen by the CSR block
	typedef struct packed {
		logic	level;		// Stable level
		logic	press;		// One-cycle pulse on rising level
		logic	longPress;	// One-cycle pulse at hold threshold
	} swEvent_t;

	//----------------------------------------------------------------------
	// Register map
	//----------------------------------------------------------------------
	localparam logic [6:0] lpRegId		= 7'h00;	// Version and custom code
	localparam logic [6:0] lpRegLevel	= 7'h04;	// Debounced levels
	localparam logic [6:0] lpRegPress	= 7'h08;	// Sticky press, W1C
	localparam logic [6:0] lpRegLong	= 7'h0C;	// Sticky long press, W1C
	localparam logic [6:0] lpRegIrqMask	= 7'h10;	// Press mask low, long mask high
	localparam logic [6:0] lpRegLongTh	= 7'h14;	// Long-press threshold in ticks

	// Threshold after reset, in sample ticks
	localparam logic [7:0] lpLongThReset = 8'd16;

	// Equal samples needed before a new level is taken
	localparam int unsigned lpStableTicks = 3;

endpackage

/* hw/SwInputStage.sv */
//--------------------------------------------------------------------
// Front end of the switch path. Brings the raw push switches into
// the iMCLK domain through a double flop and makes the common
// sample tick shared by every debounce channel.
//--------------------------------------------------------------------
module SwInputStage #(
	parameter int pSwNum	= 12,
	parameter int pTickDiv	= 64
)(
	input  logic				iMCLK,
	input  logic				qnARST,
	input  logic [pSwNum-1:0]	iPushSw,
	output logic [pSwNum-1:0]	swSync,
	output logic				sampleTick
);

	// Prescaler width, at least one bit
	localparam int lpCntW = (pTickDiv > 1) ? $clog2(pTickDiv) : 1;

	logic [pSwNum-1:0]	rMeta;
	logic [lpCntW-1:0]	rTickCnt;

	//----------------------------------------------------------------------
	// Synchroniser
	//----------------------------------------------------------------------
	always_ff @(posedge iMCLK, negedge qnARST)
	begin
		if (!qnARST)
		begin
			rMeta	<= '0;
			swSync	<= '0;
		end
		else
		begin
			// First stage may go metastable
			rMeta	<= iPushSw;
			swSync	<= rMeta;
		end
	end

	//----------------------------------------------------------------------
	// Sample tick prescaler
	//----------------------------------------------------------------------
	always_ff @(posedge iMCLK, negedge qnARST)
	begin
		if (!qnARST)
		begin
			rTickCnt	<= '0;
			sampleTick	<= 1'b0;
		end
		else
		begin
			// Down count, reload on zero
			if (rTickCnt == '0)
				rTickCnt <= lpCntW'(pTickDiv - 1);
			else
				rTickCnt <= rTickCnt - 1'b1;
			// One pulse per pTickDiv cycles
			sampleTick <= (rTickCnt == '0);
		end
	end

endmodule

/* hw/SwChannel.sv */
//--------------------------------------------------------------------
// Debounce channel for a single push switch. Samples the
// synchronised input on each sample tick, accepts a new level after
// lpStableTicks equal samples, and reports press and long-press
// pulses. One copy per switch, placed by the top level.
//--------------------------------------------------------------------
module SwChannel
	import TryPadPkg::*;
(
	input  logic		iMCLK,
	input  logic		qnARST,
	input  logic		swIn,
	input  logic		sampleTick,
	input  logic [7:0]	longTh,
	output swEvent_t	chEvent
);

	// Counter for samples that differ from the level
	localparam int lpCntW = $clog2(lpStableTicks + 1);

	logic				rLevel;
	logic [lpCntW-1:0]	rStableCnt;
	logic				rPress;
	logic [7:0]			rHoldCnt;
	logic				rLong;
	logic				wAccept;
	logic				wLongHit;

	// Last differing sample before the level flips
	assign wAccept = sampleTick && (swIn != rLevel)
		&& (rStableCnt == lpCntW'(lpStableTicks - 1));

	// Held exactly longTh ticks, zero threshold disables
	assign wLongHit = sampleTick && rLevel && (longTh != 8'd0)
		&& (rHoldCnt == longTh - 8'd1);

	//----------------------------------------------------------------------
	// Debounce and press pulse
	//----------------------------------------------------------------------
	always_ff @(posedge iMCLK, negedge qnARST)
	begin
		if (!qnARST)
		begin
			rLevel		<= 1'b0;
			rStableCnt	<= '0;
			rPress		<= 1'b0;
		end
		else
		begin
			// Rising acceptance only
			rPress <= wAccept && swIn;
			if (sampleTick)
			begin
				if (swIn == rLevel)
					rStableCnt <= '0;
				else if (wAccept)
				begin
					rLevel		<= swIn;
					rStableCnt	<= '0;
				end
				else
					rStableCnt <= rStableCnt + 1'b1;
			end
		end
	end

	//----------------------------------------------------------------------
	// Hold counter and long-press pulse
	//----------------------------------------------------------------------
	always_ff @(posedge iMCLK, negedge qnARST)
	begin
		if (!qnARST)
		begin
			rHoldCnt	<= '0;
			rLong		<= 1'b0;
		end
		else
		begin
			rLong <= wLongHit;
			// Saturate so the hit cannot repeat
			if (!rLevel)
				rHoldCnt <= '0;
			else if (sampleTick && (rHoldCnt != 8'hFF))
				rHoldCnt <= rHoldCnt + 8'd1;
		end
	end

	assign chEvent.level		= rLevel;
	assign chEvent.press		= rPress;
	assign chEvent.longPress	= rLong;

endmodule

/* hw/SwCsr.sv */
//--------------------------------------------------------------------
// APB register block of the switch path. Collects the events of all
// channels into level, sticky press and sticky long-press registers,
// holds the interrupt mask and the long-press threshold, and drives
// the registered interrupt. Zero wait state slave.
//--------------------------------------------------------------------
module SwCsr
	import TryPadPkg::*;
#(
	parameter int			pSwNum			= 12,
	parameter logic [15:0]	pSystemVersion	= 16'h0001,
	parameter logic [15:0]	pCustomCode		= 16'h5450
)(
	input  logic		iMCLK,
	input  logic		qnARST,
	input  swEvent_t	events [pSwNum],
	input  apbReq_t		apbReq,
	output apbRsp_t		apbRsp,
	output logic [7:0]	longTh,
	output logic		oIrq
);

	logic [pSwNum-1:0]		wEvLevel;
	logic [pSwNum-1:0]		wEvPress;
	logic [pSwNum-1:0]		wEvLong;
	logic [pSwNum-1:0]		rLevel;
	logic [pSwNum-1:0]		rPressFlag;
	logic [pSwNum-1:0]		rLongFlag;
	logic [2*pSwNum-1:0]	rIrqMask;
	logic [7:0]				rLongTh;
	logic [31:0]			rPrdata;
	logic					rPslverr;
	logic [31:0]			wRdData;
	logic					wUnmapped;
	logic					wSetup;
	logic					wWrEn;
	logic [pSwNum-1:0]		wPressClr;
	logic [pSwNum-1:0]		wLongClr;

	// Split the event array into vectors
	always_comb
	begin
		for (int i = 0; i < pSwNum; i++)
		begin
			wEvLevel[i]	= events[i].level;
			wEvPress[i]	= events[i].press;
			wEvLong[i]	= events[i].longPress;
		end
	end

	//----------------------------------------------------------------------
	// APB decode
	//----------------------------------------------------------------------
	assign wSetup	= apbReq.psel && !apbReq.penable;
	// Writes land at the end of the access cycle
	assign wWrEn	= apbReq.psel && apbReq.penable && apbReq.pwrite;

	always_comb
	begin
		wRdData		= '0;
		wUnmapped	= 1'b0;
		case (apbReq.paddr)
			lpRegId:		wRdData = {pSystemVersion, pCustomCode};
			lpRegLevel:		wRdData = 32'(rLevel);
			lpRegPress:		wRdData = 32'(rPressFlag);
			lpRegLong:		wRdData = 32'(rLongFlag);
			lpRegIrqMask:	wRdData = 32'(rIrqMask);
			lpRegLongTh:	wRdData = 32'(rLongTh);
			default:		wUnmapped = 1'b1;
		endcase
	end

	// Write-one-to-clear masks
	assign wPressClr = (wWrEn && (apbReq.paddr == lpRegPress))
		? apbReq.pwdata[pSwNum-1:0] : '0;
	assign wLongClr = (wWrEn && (apbReq.paddr == lpRegLong))
		? apbReq.pwdata[pSwNum-1:0] : '0;

	//----------------------------------------------------------------------
	// Response, captured in setup for the access cycle
	//----------------------------------------------------------------------
	always_ff @(posedge iMCLK, negedge qnARST)
	begin
		if (!qnARST)
		begin
			rPrdata		<= '0;
			rPslverr	<= 1'b0;
		end
		else
		begin
			rPrdata		<= (wSetup && !apbReq.pwrite) ? wRdData : '0;
			rPslverr	<= wSetup && wUnmapped;
		end
	end

	//----------------------------------------------------------------------
	// Registers
	//----------------------------------------------------------------------
	always_ff @(posedge iMCLK, negedge qnARST)
	begin
		if (!qnARST)
		begin
			rLevel		<= '0;
			rPressFlag	<= '0;
			rLongFlag	<= '0;
			rIrqMask	<= '0;
			rLongTh		<= lpLongThReset;
			oIrq		<= 1'b0;
		end
		else
		begin
			rLevel <= wEvLevel;
			// New event wins over a clear in the same cycle
			rPressFlag	<= (rPressFlag & ~wPressClr) | wEvPress;
			rLongFlag	<= (rLongFlag & ~wLongClr) | wEvLong;
			if (wWrEn && (apbReq.paddr == lpRegIrqMask))
				rIrqMask <= apbReq.pwdata[2*pSwNum-1:0];
			if (wWrEn && (apbReq.paddr == lpRegLongTh))
				rLongTh <= apbReq.pwdata[7:0];
			// Long-press mask sits above press mask
			oIrq <= |({rLongFlag, rPressFlag} & rIrqMask);
		end
	end

	assign apbRsp.prdata	= rPrdata;
	assign apbRsp.pready	= 1'b1;
	assign apbRsp.pslverr	= rPslverr;
	assign longTh			= rLongTh;

endmodule

/* hw/TryPadSwTop.sv */
//--------------------------------------------------------------------
// Top level of the push-switch path. Sets the switch count, tick
// divider and identification, then wires the input stage, one
// debounce channel per switch and the APB register block.
//--------------------------------------------------------------------
module TryPadSwTop
	import TryPadPkg::*;
#(
	parameter int			pSwNum			= 12,
	parameter int			pTickDiv		= 64,
	parameter logic [15:0]	pSystemVersion	= 16'h0001,
	parameter logic [15:0]	pCustomCode		= 16'h5450
)(
	input  logic				iMCLK,
	input  logic				qnARST,
	input  logic [pSwNum-1:0]	iPushSw,
	input  apbReq_t				apbReq,
	output apbRsp_t				apbRsp,
	output logic				oIrq
);

	logic [pSwNum-1:0]	swSync;
	logic				sampleTick;
	logic [7:0]			longTh;
	swEvent_t			chEvents [pSwNum];

	// Synchroniser and shared tick
	SwInputStage #(
		.pSwNum(pSwNum),
		.pTickDiv(pTickDiv)
	) SwInputStage_inst (
		.iMCLK(iMCLK),			.qnARST(qnARST),
		.iPushSw(iPushSw),		.swSync(swSync),
		.sampleTick(sampleTick)
	);

	//----------------------------------------------------------------------
	// One debounce channel per switch
	//----------------------------------------------------------------------
	for (genvar i = 0; i < pSwNum; i++)
	begin : gChannel
		SwChannel SwChannel_inst (
			.iMCLK(iMCLK),				.qnARST(qnARST),
			.swIn(swSync[i]),			.sampleTick(sampleTick),
			.longTh(longTh),			.chEvent(chEvents[i])
		);
	end

	// CPU side registers
	SwCsr #(
		.pSwNum(pSwNum),
		.pSystemVersion(pSystemVersion),
		.pCustomCode(pCustomCode)
	) SwCsr_inst (
		.iMCLK(iMCLK),			.qnARST(qnARST),
		.events(chEvents),
		.apbReq(apbReq),		.apbRsp(apbRsp),
		.longTh(longTh),		.oIrq(oIrq)
	);

endmodule

/* tb/TryPadSwApb_sva.sv */
//----------------------------------------------------------------------
// Protocol and interrupt assertions for the switch CSR block.
// Bound into every SwCsr instance. A failing assertion is reported
// with $error and counted, and the testbench adds up the count.
//----------------------------------------------------------------------
module TryPadSwApb_sva
	import TryPadPkg::*;
#(
	parameter int pSwNum = 12
)(
	input logic					iMCLK,
	input logic					qnARST,
	input apbReq_t				apbReq,
	input apbRsp_t				apbRsp,
	input logic [2*pSwNum-1:0]	irqMask,
	input logic					oIrq
);
	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0;

	// Error response only in the access cycle
	assert property (@(posedge iMCLK) disable iff (!qnARST)
		apbRsp.pslverr |-> (apbReq.psel && apbReq.penable))
	else
	begin
		failCount++;
		$error("pslverr high outside an APB access cycle");
	end

	// Zero wait state slave
	assert property (@(posedge iMCLK) disable iff (!qnARST) apbRsp.pready)
	else
	begin
		failCount++;
		$error("pready low");
	end

	// oIrq is registered, so it follows the mask one cycle late
	assert property (@(posedge iMCLK) disable iff (!qnARST)
		($past(irqMask) == '0) |-> !oIrq)
	else
	begin
		failCount++;
		$error("oIrq high while the interrupt mask is zero");
	end

endmodule

bind SwCsr TryPadSwApb_sva #(.pSwNum(pSwNum)) TryPadSwApb_sva_inst (
	.iMCLK(iMCLK),		.qnARST(qnARST),
	.apbReq(apbReq),	.apbRsp(apbRsp),
	.irqMask(rIrqMask),	.oIrq(oIrq)
);

/* tb/TryPadSwTb.sv */
//----------------------------------------------------------------------
// Testbench for the push-switch path. Checks the CSR block after
// reset, then applies a table of switch patterns with optional LFSR
// glitches, thresholds and masks, and checks LEVEL, PRESS, LONG and
// oIrq over APB. Run as the simulation top with the file list.
//----------------------------------------------------------------------
module TryPadSwTb
	import TryPadPkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int lpSwNum		= 12;
	localparam int lpTickDiv	= 4;
	localparam int lpPeriod		= 8;
	localparam logic [15:0] lpVersion	= 16'h0102;
	localparam logic [15:0] lpCustom	= 16'h5450;
	// Sync, stable window plus one tick, LEVEL register and oIrq
	localparam int lpSettle		= 2 + (lpStableTicks + 1) * lpTickDiv + 2;
	localparam int lpRows		= 6;
	localparam int lpMaxHold	= 10;
	// Row length with APB traffic and release, in cycles
	localparam int lpRowCycles	= 2 * lpSettle + lpMaxHold * lpTickDiv + 80;
	localparam int lpWatchdogNs	= lpRows * lpRowCycles * 2 * lpPeriod;

	typedef struct packed {
		logic [11:0]	pattern;
		logic [7:0]		holdTicks;
		logic			bounce;
		logic [7:0]		longTh;
		logic [23:0]	irqMask;
		logic [11:0]	expLevel;
		logic [11:0]	expPress;
		logic [11:0]	expLong;
		logic			expIrq;
	} rowSpec_t;

	logic				iMCLK;
	logic				qnARST;
	logic [lpSwNum-1:0]	iPushSw;
	apbReq_t			apbReq;
	apbRsp_t			apbRsp;
	logic				oIrq;

	rowSpec_t		rows [lpRows];
	logic [31:0]	lfsrState = 32'h980fffe5;
	int				errCount = 0;
	int				checkCount = 0;

	TryPadSwTop #(
		.pSwNum(lpSwNum),
		.pTickDiv(lpTickDiv),
		.pSystemVersion(lpVersion),
		.pCustomCode(lpCustom)
	) TryPadSwTop_inst (
		.iMCLK(iMCLK),		.qnARST(qnARST),
		.iPushSw(iPushSw),	.apbReq(apbReq),
		.apbRsp(apbRsp),	.oIrq(oIrq)
	);

	always #(lpPeriod / 2) iMCLK = ~iMCLK;

	//------------------------------------------------------------------
	// Helpers
	//------------------------------------------------------------------
	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	task automatic takeRandomBits(output logic [lpSwNum-1:0] bits);
		for (int i = 0; i < lpSwNum; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			bits[i] = lfsrState[0];
		end
	endtask

	task automatic checkValue(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		checkCount++;
		if (actVal !== expVal)
		begin
			$display("Error at %0d ns: %s expected 0x%h, got 0x%h",
				$time, name, expVal, actVal);
			errCount++;
		end
	endtask

	// Setup cycle, then access cycle, one idle cycle after
	task automatic apbWrite(input logic [6:0] addr, input logic [31:0] data,
		output logic err);
		@(negedge iMCLK);
		apbReq.psel		= 1'b1;
		apbReq.penable	= 1'b0;
		apbReq.pwrite	= 1'b1;
		apbReq.paddr	= addr;
		apbReq.pwdata	= data;
		@(negedge iMCLK);
		apbReq.penable	= 1'b1;
		checkValue("pready", 32'd1, 32'(apbRsp.pready));
		err = apbRsp.pslverr;
		@(negedge iMCLK);
		apbReq = '0;
	endtask

	task automatic apbRead(input logic [6:0] addr, output logic [31:0] data,
		output logic err);
		@(negedge iMCLK);
		apbReq.psel		= 1'b1;
		apbReq.penable	= 1'b0;
		apbReq.pwrite	= 1'b0;
		apbReq.paddr	= addr;
		@(negedge iMCLK);
		apbReq.penable	= 1'b1;
		checkValue("pready", 32'd1, 32'(apbRsp.pready));
		data = apbRsp.prdata;
		err = apbRsp.pslverr;
		@(negedge iMCLK);
		apbReq = '0;
	endtask

	task automatic readAndCheck(input logic [6:0] addr, input string name,
		input logic [31:0] expVal);
		logic [31:0]	data;
		logic			err;
		apbRead(addr, data, err);
		checkValue({name, " pslverr"}, 32'd0, 32'(err));
		checkValue(name, expVal, data);
	endtask

	//------------------------------------------------------------------
	// Reset state, read-only and unmapped accesses
	//------------------------------------------------------------------
	task automatic resetChecks();
		logic [31:0]	data;
		logic			err;
		readAndCheck(lpRegId, "ID", {lpVersion, lpCustom});
		readAndCheck(lpRegLevel, "LEVEL", 32'd0);
		readAndCheck(lpRegPress, "PRESS", 32'd0);
		readAndCheck(lpRegLong, "LONG", 32'd0);
		readAndCheck(lpRegIrqMask, "IRQMASK", 32'd0);
		readAndCheck(lpRegLongTh, "LONGTH", 32'd16);
		checkValue("oIrq", 32'd0, 32'(oIrq));
		// Read-only ID ignores writes
		apbWrite(lpRegId, 32'hFFFF_FFFF, err);
		readAndCheck(lpRegId, "ID", {lpVersion, lpCustom});
		apbRead(7'h18, data, err);
		checkValue("unmapped read pslverr", 32'd1, 32'(err));
		checkValue("unmapped read prdata", 32'd0, data);
		apbWrite(7'h7C, 32'hFFFF_FFFF, err);
		checkValue("unmapped write pslverr", 32'd1, 32'(err));
		readAndCheck(lpRegIrqMask, "IRQMASK", 32'd0);
		readAndCheck(lpRegLongTh, "LONGTH", 32'd16);
		$display("Reset and decode checks: %s", (errCount == 0) ? "ok" : "FAILED");
	endtask

	//------------------------------------------------------------------
	// One table row
	//------------------------------------------------------------------
	task automatic runRow(input int idx, input rowSpec_t row);
		logic [lpSwNum-1:0]	glitch;
		logic				err;
		int					errsBefore;
		errsBefore = errCount;
		apbWrite(lpRegLongTh, 32'(row.longTh), err);
		apbWrite(lpRegIrqMask, 32'(row.irqMask), err);
		if (row.bounce)
		begin
			// One-tick glitch on bits that stay released
			takeRandomBits(glitch);
			iPushSw = glitch & ~row.pattern;
			repeat (lpTickDiv) @(negedge iMCLK);
			iPushSw = '0;
			repeat (lpTickDiv) @(negedge iMCLK);
		end
		iPushSw = row.pattern;
		repeat (lpSettle + int'(row.holdTicks) * lpTickDiv) @(negedge iMCLK);
		readAndCheck(lpRegLevel, "LEVEL", 32'(row.expLevel));
		readAndCheck(lpRegPress, "PRESS", 32'(row.expPress));
		readAndCheck(lpRegLong, "LONG", 32'(row.expLong));
		checkValue("oIrq", 32'(row.expIrq), 32'(oIrq));
		// Partial clear leaves the other bits set
		apbWrite(lpRegPress, 32'h0000_000F, err);
		readAndCheck(lpRegPress, "PRESS", 32'(row.expPress & 12'hFF0));
		apbWrite(lpRegPress, 32'h0000_0FFF, err);
		apbWrite(lpRegLong, 32'h0000_0FFF, err);
		repeat (2) @(negedge iMCLK);
		checkValue("oIrq after clear", 32'd0, 32'(oIrq));
		iPushSw = '0;
		repeat (lpSettle) @(negedge iMCLK);
		$display("Row %0d pattern 0x%h: %s", idx, row.pattern,
			(errCount == errsBefore) ? "ok" : "FAILED");
	endtask

	//------------------------------------------------------------------
	// Main sequence
	//------------------------------------------------------------------
	initial
	begin
		int svaFails;
		iMCLK	= 1'b0;
		qnARST	= 1'b0;
		iPushSw	= '0;
		apbReq	= '0;
		// pattern hold bounce th mask level press long irq
		rows[0] = '{12'h005, 8'd4, 1'b0, 8'd40, 24'h000000, 12'h005, 12'h005, 12'h000, 1'b0};
		rows[1] = '{12'hA30, 8'd4, 1'b1, 8'd40, 24'h000010, 12'hA30, 12'hA30, 12'h000, 1'b1};
		rows[2] = '{12'h0C0, 8'd10, 1'b0, 8'd4, 24'h0C0000, 12'h0C0, 12'h0C0, 12'h0C0, 1'b1};
		rows[3] = '{12'h300, 8'd10, 1'b1, 8'd0, 24'h300000, 12'h300, 12'h300, 12'h000, 1'b0};
		rows[4] = '{12'h842, 8'd4, 1'b1, 8'd40, 24'h000800, 12'h842, 12'h842, 12'h000, 1'b1};
		rows[5] = '{12'h00F, 8'd10, 1'b0, 8'd3, 24'h00F000, 12'h00F, 12'h00F, 12'h00F, 1'b1};
		repeat (10) @(negedge iMCLK);
		qnARST = 1'b1;
		resetChecks();
		for (int r = 0; r < lpRows; r++)
			runRow(r, rows[r]);
		svaFails = TryPadSwTop_inst.SwCsr_inst.TryPadSwApb_sva_inst.failCount;
		errCount += svaFails;
		$display("Rows %0d, checks %0d, assertion failures %0d, errors %0d",
			lpRows, checkCount, svaFails, errCount);
		if (errCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(lpWatchdogNs);
		$display("Timeout after %0d ns, the test sequence did not finish", lpWatchdogNs);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* project.f */
hw/TryPadPkg.sv
hw/SwInputStage.sv
hw/SwChannel.sv
hw/SwCsr.sv
hw/TryPadSwTop.sv
tb/TryPadSwApb_sva.sv
tb/TryPadSwTb.sv

/* run.sh */
#!/bin/sh
# Build and run the push-switch testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module TryPadSwTb -f project.f -o TryPadSwSim

# Let the testbench collect assertion failures itself
./obj_dir/TryPadSwSim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	exit 0
fi
exit 1
